/* l2_cache.f */
hdl/l2_cache_pkg.sv
hdl/eviction_buffer.sv
hdl/plru_tree.sv
hdl/way_arrays.sv
hdl/cache_control.sv
hdl/l2_cache.sv
tb/tb_clock.sv
tb/l2_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the L2 cache testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module l2_cache_tb \
    -f l2_cache.f -o l2_cache_sim
output=$(./obj_dir/l2_cache_sim 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "sim passed"; then
    echo "simulation result: PASS"
else
    echo "simulation result: FAIL"
    exit 1
fi

/* tb/l2_cache_tb.sv */
// L2 cache testbench; memory delay 1 to 4 cycles from a fixed seed, one request at a time
`timescale 1ns/1ns
module l2_cache_tb;
    import l2_cache_pkg::*;

    localparam int REQ_TIMEOUT = 100;
    localparam int DRAIN_TIMEOUT = 40;
    localparam int NUM_SETS = 2**SET_BITS;

    logic clk;
    logic rst;
    cpu_req_t req;
    line_t rdata;
    logic resp;
    pmem_req_t pmem;
    line_t pmem_rdata;
    logic pmem_resp;
    int seed = 36639;

    // memory behind the cache and the value each read must return
    line_t backing [0:2**ADDR_BITS-1];
    line_t shadow [0:2**ADDR_BITS-1];

    // memory model bookkeeping
    int read_count;
    int write_count;
    logic [ADDR_BITS-1:0] last_read_addr;
    logic [ADDR_BITS-1:0] last_write_addr;
    line_t last_write_data;
    logic mem_busy;
    int mem_wait;

    // expected cache state
    logic [TAG_BITS-1:0] sh_tag [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] sh_valid [NUM_SETS];
    logic [NUM_WAYS-1:0] sh_dirty [NUM_SETS];
    plru_t sh_plru [NUM_SETS];
    logic sh_ewb_full;
    logic [ADDR_BITS-1:0] sh_ewb_addr;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    l2_cache uut (
        .clk(clk),
        .rst(rst),
        .req(req),
        .rdata(rdata),
        .resp(resp),
        .pmem(pmem),
        .pmem_rdata(pmem_rdata),
        .pmem_resp(pmem_resp)
    );

    // every address gets its own initial contents
    function automatic line_t fill_pattern(input logic [ADDR_BITS-1:0] a);
        return {a ^ 16'hc35a, ~a, a * 16'd13 + 16'd7, a};
    endfunction

    function automatic logic [ADDR_BITS-1:0] line_addr(input int tag, input int set);
        return {TAG_BITS'(tag), SET_BITS'(set)};
    endfunction

    // bit 2 low walks to the upper pair
    function automatic way_t tree_victim(input plru_t b);
        if (!b[2])
            return b[0] ? way_t'(2) : way_t'(3);
        return b[1] ? way_t'(0) : way_t'(1);
    endfunction

    function automatic plru_t tree_touch(input plru_t b, input way_t w);
        plru_t n;
        n = b;
        n[2] = w[1];
        if (w[1])
            n[0] = w[0];
        else
            n[1] = w[0];
        return n;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [LINE_BITS-1:0] got,
                               input logic [LINE_BITS-1:0] exp);
        assert (got === exp)
        else stop_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_true(input logic cond, input string why);
        assert (cond)
        else stop_run(why);
    endtask

    // memory model answers each held request after a random delay
    always @(negedge clk)
    begin
        if (rst)
        begin
            pmem_resp <= 1'b0;
            mem_busy = 1'b0;
        end
        else if (pmem_resp)
            pmem_resp <= 1'b0;
        else if (pmem.read || pmem.write)
        begin
            check_true(!(pmem.read && pmem.write), "memory read and write raised together");
            if (!mem_busy)
            begin
                mem_busy = 1'b1;
                mem_wait = $random(seed) & 3;
            end
            if (mem_wait == 0)
            begin
                mem_busy = 1'b0;
                pmem_resp <= 1'b1;
                if (pmem.read)
                begin
                    pmem_rdata <= backing[pmem.addr];
                    read_count++;
                    last_read_addr = pmem.addr;
                end
                else
                begin
                    backing[pmem.addr] = pmem.wdata;
                    write_count++;
                    last_write_addr = pmem.addr;
                    last_write_data = pmem.wdata;
                end
            end
            else
                mem_wait--;
        end
    end

    // shadow of one request through hit, EWB service or miss
    task automatic model_access(input logic [ADDR_BITS-1:0] addr, input logic is_write,
                                input line_t wdata, output int exp_reads,
                                output int exp_writes, output logic [ADDR_BITS-1:0] exp_wr_addr,
                                output logic exp_fast);
        int set;
        logic [TAG_BITS-1:0] tag;
        logic found;
        logic have_invalid;
        way_t w;
        set = int'(addr[SET_BITS-1:0]);
        tag = addr[ADDR_BITS-1:SET_BITS];
        found = 1'b0;
        have_invalid = 1'b0;
        w = '0;
        exp_reads = 0;
        exp_writes = 0;
        exp_wr_addr = '0;
        exp_fast = 1'b0;
        for (int i = 0; i < NUM_WAYS; i++)
        begin
            if (sh_valid[set][i] && sh_tag[set][i] == tag)
            begin
                found = 1'b1;
                w = way_t'(i);
            end
        end
        if (!found && sh_ewb_full && sh_ewb_addr == addr)
            exp_fast = 1'b1;
        else
        begin
            if (!found)
            begin
                exp_reads = 1;
                // lowest invalid way first
                for (int i = NUM_WAYS - 1; i >= 0; i--)
                begin
                    if (!sh_valid[set][i])
                    begin
                        have_invalid = 1'b1;
                        w = way_t'(i);
                    end
                end
                if (!have_invalid)
                begin
                    w = tree_victim(sh_plru[set]);
                    if (sh_dirty[set][w])
                    begin
                        if (sh_ewb_full)
                        begin
                            exp_writes = 1;
                            exp_wr_addr = sh_ewb_addr;
                        end
                        sh_ewb_full = 1'b1;
                        sh_ewb_addr = line_addr(int'(sh_tag[set][w]), set);
                    end
                end
                sh_tag[set][w] = tag;
                sh_valid[set][w] = 1'b1;
                sh_dirty[set][w] = 1'b0;
            end
            else
                exp_fast = 1'b1;
            sh_plru[set] = tree_touch(sh_plru[set], w);
            if (is_write)
                sh_dirty[set][w] = 1'b1;
        end
        if (is_write)
            shadow[addr] = wdata;
    endtask

    // one request through to resp and the memory traffic it caused
    task automatic access(input logic is_write, input logic [ADDR_BITS-1:0] addr,
                          input line_t wdata);
        int rd0;
        int wr0;
        int cycles;
        int exp_reads;
        int exp_writes;
        logic [ADDR_BITS-1:0] exp_wr_addr;
        logic exp_fast;
        logic done;
        line_t got;
        rd0 = read_count;
        wr0 = write_count;
        model_access(addr, is_write, wdata, exp_reads, exp_writes, exp_wr_addr, exp_fast);
        req.read = !is_write;
        req.write = is_write;
        req.addr.raw = addr;
        req.wdata = wdata;
        cycles = 0;
        done = 1'b0;
        got = '0;
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            if (resp)
            begin
                done = 1'b1;
                got = rdata;
            end
            else if (cycles >= REQ_TIMEOUT)
                stop_run($sformatf("request to address %h never got a response", addr));
        end
        // held through the edge that ends the resp cycle
        @(negedge clk);
        check_value("resp", resp, 1'b0);
        req = '0;
        if (!is_write)
            check_value("rdata", got, shadow[addr]);
        if (exp_fast)
            check_value("hit latency", cycles, 1);
        check_value("pmem read count", read_count - rd0, exp_reads);
        if (exp_reads != 0)
            check_value("pmem.addr", last_read_addr, addr);
        check_value("pmem write count", write_count - wr0, exp_writes);
        if (exp_writes != 0)
        begin
            check_value("pmem.addr", last_write_addr, exp_wr_addr);
            check_value("pmem.wdata", last_write_data, shadow[exp_wr_addr]);
        end
    endtask

    task automatic quiet_cycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            check_value("resp", resp, 1'b0);
            check_value("pmem.read", pmem.read, 1'b0);
            check_value("pmem.write", pmem.write, 1'b0);
        end
    endtask

    // idle until any buffered line reaches memory
    task automatic idle_drain();
        int wr0;
        int cycles;
        wr0 = write_count;
        cycles = 0;
        if (sh_ewb_full)
        begin
            while (write_count == wr0)
            begin
                @(negedge clk);
                cycles++;
                if (cycles >= DRAIN_TIMEOUT)
                    stop_run("buffered dirty line was not written back while idle");
            end
            check_true(cycles >= DRAIN_IDLE_CYCLES, "write-back started before the idle count");
            check_value("pmem.addr", last_write_addr, sh_ewb_addr);
            check_value("pmem.wdata", last_write_data, shadow[sh_ewb_addr]);
            sh_ewb_full = 1'b0;
            repeat (2) @(negedge clk);
        end
        quiet_cycles(4);
    endtask

    initial
    begin
        logic [ADDR_BITS-1:0] d_addr;
        int tries;
        int tag;
        req = '0;
        pmem_rdata = '0;
        pmem_resp = 1'b0;
        read_count = 0;
        write_count = 0;
        mem_busy = 1'b0;
        mem_wait = 0;
        sh_ewb_full = 1'b0;
        sh_ewb_addr = '0;
        for (int a = 0; a < 2**ADDR_BITS; a++)
        begin
            backing[a] = fill_pattern(ADDR_BITS'(a));
            shadow[a] = fill_pattern(ADDR_BITS'(a));
        end
        for (int s = 0; s < NUM_SETS; s++)
        begin
            sh_valid[s] = '0;
            sh_dirty[s] = '0;
            sh_plru[s] = '0;
        end

        tries = 0;
        while (rst)
        begin
            @(negedge clk);
            tries++;
            if (tries > 20)
                stop_run("reset never released");
        end

        // nothing moves without a request
        quiet_cycles(10);

        // fresh read misses and the repeat hits
        access(1'b0, line_addr(2, 3), '0);
        access(1'b0, line_addr(2, 3), '0);

        // write then read back
        access(1'b1, line_addr(4, 4), 64'h0123_4567_89ab_cdef);
        access(1'b0, line_addr(4, 4), '0);
        access(1'b1, line_addr(2, 3), 64'hfeed_face_cafe_beef);
        access(1'b0, line_addr(2, 3), '0);

        // five clean tags in one set and a revisit of all
        for (int t = 1; t <= 5; t++)
            access(1'b0, line_addr(t, 5), '0);
        for (int t = 1; t <= 5; t++)
            access(1'b0, line_addr(t, 5), '0);

        // dirty line pushed into the EWB by fresh tags
        d_addr = line_addr(1, 6);
        access(1'b1, d_addr, 64'h1111_2222_3333_4444);
        tag = 2;
        while (!(sh_ewb_full && sh_ewb_addr == d_addr))
        begin
            access(1'b0, line_addr(tag, 6), '0);
            tag++;
            if (tag > 12)
                stop_run("dirty line was never evicted");
        end
        access(1'b0, d_addr, '0);
        access(1'b1, d_addr, 64'h5555_6666_7777_8888);
        access(1'b0, d_addr, '0);
        idle_drain();
        // comes back from memory with the drained data
        access(1'b0, d_addr, '0);

        // random mix over two sets
        for (int i = 0; i < 200; i++)
        begin
            tag = $random(seed) & 7;
            access(1'(($random(seed) & 1) != 0), line_addr(tag, 1 + ($random(seed) & 1)),
                   {$random(seed), $random(seed)});
        end
        idle_drain();

        $display("sim passed");
        $finish;
    end

endmodule

/* tb/tb_clock.sv */
// clock and reset source; 10 ns period, reset high for three rising edges
`timescale 1ns/1ns
module tb_clock (
    output logic clk,
    output logic rst
);
    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    // released on a falling edge like the other inputs
    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end
endmodule

/* hdl/l2_cache.sv */
// L2 cache top; one outstanding request, whole-line writes, single-entry eviction buffer
`timescale 1ns/1ns
module l2_cache (
    input  logic                    clk,
    input  logic                    rst,
    input  l2_cache_pkg::cpu_req_t  req,
    output l2_cache_pkg::line_t     rdata,
    output logic                    resp,
    output l2_cache_pkg::pmem_req_t pmem,
    input  l2_cache_pkg::line_t     pmem_rdata,
    input  logic                    pmem_resp
);
    import l2_cache_pkg::*;

    way_op_t way_op;
    logic plru_update;
    logic ewb_load;
    logic ewb_update;
    logic ewb_clear;
    logic hit;
    way_t hit_way;
    logic all_valid;
    way_t first_invalid;
    way_t victim_way;
    logic victim_dirty;
    logic [TAG_BITS-1:0] victim_tag;
    line_t victim_data;
    line_t hit_data;
    logic ewb_full;
    logic ewb_match;
    logic [ADDR_BITS-1:0] held_addr;
    line_t held_data;
    logic draining;
    logic pmem_read;
    logic pmem_write;
    line_addr_u victim_addr;

    // victim shares the set of the request
    assign victim_addr.f.tag = victim_tag;
    assign victim_addr.f.set_index = req.addr.f.set_index;

    cache_control control (
        .clk(clk),
        .rst(rst),
        .req(req),
        .hit(hit),
        .hit_way(hit_way),
        .all_valid(all_valid),
        .first_invalid(first_invalid),
        .victim_way(victim_way),
        .victim_dirty(victim_dirty),
        .ewb_full(ewb_full),
        .ewb_match(ewb_match),
        .pmem_resp(pmem_resp),
        .resp(resp),
        .draining(draining),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write),
        .way_op(way_op),
        .plru_update(plru_update),
        .ewb_load(ewb_load),
        .ewb_update(ewb_update),
        .ewb_clear(ewb_clear)
    );

    way_arrays arrays (
        .clk(clk),
        .rst(rst),
        .addr(req.addr),
        .way_op(way_op),
        .wdata(req.wdata),
        .fill_data(pmem_rdata),
        .victim_way(victim_way),
        .hit(hit),
        .hit_way(hit_way),
        .all_valid(all_valid),
        .first_invalid(first_invalid),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag),
        .victim_data(victim_data),
        .hit_data(hit_data)
    );

    plru_tree plru (
        .clk(clk),
        .rst(rst),
        .set_index(req.addr.f.set_index),
        .plru_update(plru_update),
        .hit_way(hit_way),
        .victim_way(victim_way)
    );

    eviction_buffer ewb (
        .clk(clk),
        .rst(rst),
        .ewb_load(ewb_load),
        .ewb_update(ewb_update),
        .ewb_clear(ewb_clear),
        .req_addr(req.addr.raw),
        .victim_addr(victim_addr.raw),
        .victim_data(victim_data),
        .wdata(req.wdata),
        .full(ewb_full),
        .match(ewb_match),
        .held_addr(held_addr),
        .held_data(held_data)
    );

    // a line is never in the arrays and the EWB at once
    assign rdata = ewb_match ? held_data : hit_data;

    // drain writes the EWB entry and fill reads the request line
    assign pmem.read = pmem_read;
    assign pmem.write = pmem_write;
    assign pmem.addr = draining ? held_addr : req.addr.raw;
    assign pmem.wdata = held_data;

endmodule

/* hdl/cache_control.sv */
// cache FSM; the requester must hold read/write, addr and wdata steady until resp
`timescale 1ns/1ns
module cache_control (
    input  logic                    clk,
    input  logic                    rst,
    input  l2_cache_pkg::cpu_req_t  req,
    input  logic                    hit,
    input  l2_cache_pkg::way_t      hit_way,
    input  logic                    all_valid,
    input  l2_cache_pkg::way_t      first_invalid,
    input  l2_cache_pkg::way_t      victim_way,
    input  logic                    victim_dirty,
    input  logic                    ewb_full,
    input  logic                    ewb_match,
    input  logic                    pmem_resp,
    output logic                    resp,
    output logic                    draining,
    output logic                    pmem_read,
    output logic                    pmem_write,
    output l2_cache_pkg::way_op_t   way_op,
    output logic                    plru_update,
    output logic                    ewb_load,
    output logic                    ewb_update,
    output logic                    ewb_clear
);
    import l2_cache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_EVICT,
        S_FILL,
        S_DRAIN
    } state_t;

    state_t state;
    state_t next_state;
    logic [DRAIN_CNT_BITS-1:0] idle_cnt;
    logic req_active;
    way_t fill_way;

    assign req_active = req.read | req.write;

    // tree choice only once the set is full
    assign fill_way = all_valid ? victim_way : first_invalid;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    // drain countdown runs only in idle with a full EWB
    always_ff @(posedge clk)
    begin
        if (rst)
            idle_cnt <= DRAIN_CNT_BITS'(DRAIN_IDLE_CYCLES);
        else if (state == S_LOOKUP || state == S_DRAIN)
            idle_cnt <= DRAIN_CNT_BITS'(DRAIN_IDLE_CYCLES);
        else if (state == S_IDLE && ewb_full && idle_cnt != '0)
            idle_cnt <= idle_cnt - 1'b1;
    end

    always_comb
    begin
        next_state = state;
        resp = 1'b0;
        draining = 1'b0;
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        way_op = '0;
        plru_update = 1'b0;
        ewb_load = 1'b0;
        ewb_update = 1'b0;
        ewb_clear = 1'b0;

        case (state)
            S_IDLE:
            begin
                // a waiting request beats the drain
                if (req_active)
                    next_state = S_LOOKUP;
                else if (ewb_full && idle_cnt == '0)
                    next_state = S_DRAIN;
            end

            S_LOOKUP:
            begin
                if (hit)
                begin
                    resp = 1'b1;
                    plru_update = 1'b1;
                    way_op.cpu_write = req.write;
                    way_op.way = hit_way;
                    next_state = S_IDLE;
                end
                else if (ewb_match)
                begin
                    // line sits in the EWB and is served there
                    resp = 1'b1;
                    ewb_update = req.write;
                    next_state = S_IDLE;
                end
                else if (all_valid && victim_dirty)
                begin
                    // single slot is emptied before the eviction
                    next_state = ewb_full ? S_DRAIN : S_EVICT;
                end
                else
                begin
                    next_state = S_FILL;
                end
            end

            S_EVICT:
            begin
                // dirty victim moves into the EWB and its way is freed
                ewb_load = 1'b1;
                way_op.invalidate = 1'b1;
                way_op.way = victim_way;
                next_state = S_FILL;
            end

            S_FILL:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    way_op.fill = 1'b1;
                    way_op.way = fill_way;
                    // lookup again now hits
                    next_state = S_LOOKUP;
                end
            end

            S_DRAIN:
            begin
                draining = 1'b1;
                pmem_write = 1'b1;
                if (pmem_resp)
                begin
                    ewb_clear = 1'b1;
                    next_state = req_active ? S_LOOKUP : S_IDLE;
                end
            end

            default:
            begin
                next_state = S_IDLE;
            end
        endcase
    end

endmodule

/* hdl/way_arrays.sv */
// tag/valid/dirty/data for 8 sets x 4 ways; reads are combinational, writes at the edge
`timescale 1ns/1ns
module way_arrays (
    input  logic                    clk,
    input  logic                    rst,
    input  l2_cache_pkg::line_addr_u addr,
    input  l2_cache_pkg::way_op_t   way_op,
    input  l2_cache_pkg::line_t     wdata,
    input  l2_cache_pkg::line_t     fill_data,
    input  l2_cache_pkg::way_t      victim_way,
    output logic                    hit,
    output l2_cache_pkg::way_t      hit_way,
    output logic                    all_valid,
    output l2_cache_pkg::way_t      first_invalid,
    output logic                    victim_dirty,
    output logic [l2_cache_pkg::TAG_BITS-1:0] victim_tag,
    output l2_cache_pkg::line_t     victim_data,
    output l2_cache_pkg::line_t     hit_data
);
    import l2_cache_pkg::*;

    logic [TAG_BITS-1:0] tag_mem [NUM_WAYS][2**SET_BITS];
    line_t data_mem [NUM_WAYS][2**SET_BITS];
    logic [NUM_WAYS-1:0] valid [2**SET_BITS];
    logic [NUM_WAYS-1:0] dirty [2**SET_BITS];
    logic [NUM_WAYS-1:0] way_hit;
    logic [SET_BITS-1:0] set;

    assign set = addr.f.set_index;

    // compare all four tags of the set at once
    always_comb
    begin
        for (int w = 0; w < NUM_WAYS; w++)
            way_hit[w] = valid[set][w] && (tag_mem[w][set] == addr.f.tag);
    end

    // one-hot hit to index
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (way_hit[w])
                hit_way = way_t'(w);
        end
    end

    // scan downward so the lowest invalid way wins
    always_comb
    begin
        first_invalid = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!valid[set][w])
                first_invalid = way_t'(w);
        end
    end

    assign hit = |way_hit;
    assign all_valid = &valid[set];
    assign hit_data = data_mem[hit_way][set];
    assign victim_dirty = dirty[set][victim_way];
    assign victim_tag = tag_mem[victim_way][set];
    assign victim_data = data_mem[victim_way][set];

    // status bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < 2**SET_BITS; s++)
            begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end
        else if (way_op.fill)
        begin
            valid[set][way_op.way] <= 1'b1;
            dirty[set][way_op.way] <= 1'b0;
        end
        else if (way_op.cpu_write)
            dirty[set][way_op.way] <= 1'b1;
        else if (way_op.invalidate)
        begin
            valid[set][way_op.way] <= 1'b0;
            dirty[set][way_op.way] <= 1'b0;
        end
    end

    // payload
    always_ff @(posedge clk)
    begin
        if (way_op.fill)
        begin
            tag_mem[way_op.way][set] <= addr.f.tag;
            data_mem[way_op.way][set] <= fill_data;
        end
        else if (way_op.cpu_write)
            data_mem[way_op.way][set] <= wdata;
    end

endmodule

/* hdl/plru_tree.sv */
// tree pseudo-LRU, three bits per set; victim_way ignores valid bits, control handles those
`timescale 1ns/1ns
module plru_tree (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [l2_cache_pkg::SET_BITS-1:0] set_index,
    input  logic                            plru_update,
    input  l2_cache_pkg::way_t              hit_way,
    output l2_cache_pkg::way_t              victim_way
);
    import l2_cache_pkg::*;

    plru_t tree [2**SET_BITS];
    plru_t cur;
    plru_t nxt;

    assign cur = tree[set_index];

    // bit 2 low points at the upper pair
    always_comb
    begin
        if (!cur[2])
            victim_way = cur[0] ? way_t'(2) : way_t'(3);
        else
            victim_way = cur[1] ? way_t'(0) : way_t'(1);
    end

    // mark the path to the hit way and keep the other pair's bit
    always_comb
    begin
        nxt = cur;
        case (hit_way)
            2'd0:
            begin
                nxt[2] = 1'b0;
                nxt[1] = 1'b0;
            end
            2'd1:
            begin
                nxt[2] = 1'b0;
                nxt[1] = 1'b1;
            end
            2'd2:
            begin
                nxt[2] = 1'b1;
                nxt[0] = 1'b0;
            end
            default:
            begin
                nxt[2] = 1'b1;
                nxt[0] = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < 2**SET_BITS; s++)
                tree[s] <= '0;
        end
        else if (plru_update)
            tree[set_index] <= nxt;
    end

endmodule

/* hdl/eviction_buffer.sv */
// single-entry write-back buffer; a load while full would overwrite, control drains first
`timescale 1ns/1ns
module eviction_buffer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                ewb_load,
    input  logic                                ewb_update,
    input  logic                                ewb_clear,
    input  logic [l2_cache_pkg::ADDR_BITS-1:0]  req_addr,
    input  logic [l2_cache_pkg::ADDR_BITS-1:0]  victim_addr,
    input  l2_cache_pkg::line_t                 victim_data,
    input  l2_cache_pkg::line_t                 wdata,
    output logic                                full,
    output logic                                match,
    output logic [l2_cache_pkg::ADDR_BITS-1:0]  held_addr,
    output l2_cache_pkg::line_t                 held_data
);
    import l2_cache_pkg::*;

    // stale address must not hit once empty
    assign match = full && (held_addr == req_addr);

    always_ff @(posedge clk)
    begin
        if (rst)
            full <= 1'b0;
        else if (ewb_load)
            full <= 1'b1;
        else if (ewb_clear)
            full <= 1'b0;
    end

    // entry contents
    always_ff @(posedge clk)
    begin
        if (ewb_load)
        begin
            held_addr <= victim_addr;
            held_data <= victim_data;
        end
        else if (ewb_update)
        begin
            // write hit replaces the whole buffered line
            held_data <= wdata;
        end
    end

endmodule

/* hdl/l2_cache_pkg.sv */
// shared types for the four-way L2 cache; whole-line writes only, no byte enables
package l2_cache_pkg;

    // geometry
    localparam int NUM_WAYS = 4;
    localparam int WAY_BITS = 2;
    localparam int SET_BITS = 3;
    localparam int TAG_BITS = 13;
    localparam int ADDR_BITS = 16;
    localparam int LINE_BITS = 64;
    localparam int PLRU_BITS = 3;

    // idle cycles with a full EWB before it is written back
    localparam int DRAIN_IDLE_CYCLES = 7;
    localparam int DRAIN_CNT_BITS = $clog2(DRAIN_IDLE_CYCLES + 1);

    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [LINE_BITS-1:0] line_t;

    // [2] lower/upper pair, [1] inside lower pair, [0] inside upper pair
    typedef logic [PLRU_BITS-1:0] plru_t;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set_index;
    } line_fields_t;

    // one line address seen raw or as tag and set
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        line_fields_t f;
    } line_addr_u;

    typedef struct packed {
        logic read;
        logic write;
        line_addr_u addr;
        line_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic read;
        logic write;
        logic [ADDR_BITS-1:0] addr;
        line_t wdata;
    } pmem_req_t;

    // array operation for one way of the current set
    typedef struct packed {
        logic fill;
        logic cpu_write;
        logic invalidate;
        way_t way;
    } way_op_t;

endpackage
